//--- src/aluPkg.sv
package aluPkg;

  // default datapath width
  parameter int ALU_WIDTH = 32;

  // command encoding
  typedef enum logic [2:0]
  {
    cmdAdd  = 3'd0,
    cmdSub  = 3'd1,
    cmdXor  = 3'd2,
    cmdSlt  = 3'd3, // signed set-less-than
    cmdAnd  = 3'd4,
    cmdNand = 3'd5,
    cmdNor  = 3'd6,
    cmdOr   = 3'd7
  } aluCmdT;

  // what each bit slice puts on its result lane
  typedef enum logic [1:0]
  {
    opSum = 2'd0, // full adder sum for add, sub and slt
    opXor = 2'd1,
    opAnd = 2'd2, // nand when invertResult is set
    opOr  = 2'd3  // nor when invertResult is set
  } sliceOpT;

endpackage

//--- src/aluSliceIf.sv
`timescale 1ns/100ps

interface aluSliceIf #(
  parameter int WIDTH = 32
);
  import aluPkg::*;

  logic [WIDTH-1:0] opA;
  logic [WIDTH-1:0] opB;
  sliceOpT          sliceOp;
  logic             invertResult; // lane inversion for nand and nor
  logic             invertB;      // subtract mode and carry into bit 0
  aluCmdT           cmd;          // held for the collector
  logic             stageValid;

  // one lane per slice
  logic [WIDTH-1:0] resultBits;
  logic [WIDTH-1:0] carries;      // carry out of each slice

  modport decoder (
    output opA, opB, sliceOp, invertResult, invertB, cmd, stageValid
  );

  modport slice (
    input  opA, opB, sliceOp, invertResult, invertB,
    output resultBits, carries
  );

  modport collector (
    input opA, opB, sliceOp, invertResult, invertB, cmd, stageValid,
    input resultBits, carries
  );

endinterface

//--- src/aluOpDecoder.sv
`timescale 1ns/100ps

module aluOpDecoder #(
  parameter int WIDTH = 32
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               opValid,
  input  logic [WIDTH-1:0]   operandA,
  input  logic [WIDTH-1:0]   operandB,
  input  aluPkg::aluCmdT     command,
  aluSliceIf.decoder         ctrl
);
  import aluPkg::*;

  sliceOpT nextOp;
  logic    nextInvertB;
  logic    nextInvertResult;

  // command to slice controls
  always_comb
  begin
    nextOp           = opSum;
    nextInvertB      = 1'b0;
    nextInvertResult = 1'b0;
    unique case (command)
      cmdAdd:  nextOp = opSum;
      cmdSub,
      cmdSlt:
      begin
        nextOp      = opSum; // a + ~b + 1
        nextInvertB = 1'b1;
      end
      cmdXor:  nextOp = opXor;
      cmdAnd:  nextOp = opAnd;
      cmdNand:
      begin
        nextOp           = opAnd;
        nextInvertResult = 1'b1;
      end
      cmdNor:
      begin
        nextOp           = opOr;
        nextInvertResult = 1'b1;
      end
      cmdOr:   nextOp = opOr;
      default: nextOp = opSum;
    endcase
  end

  // operand capture on the strobe
  always_ff @(posedge clk)
  begin
    if (opValid)
    begin
      ctrl.opA <= operandA;
      ctrl.opB <= operandB;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ctrl.stageValid   <= 1'b0;
      ctrl.cmd          <= cmdAdd;
      ctrl.sliceOp      <= opSum;
      ctrl.invertB      <= 1'b0;
      ctrl.invertResult <= 1'b0;
    end
    else
    begin
      ctrl.stageValid <= opValid; // one cycle behind the strobe
      if (opValid)
      begin
        ctrl.cmd          <= command;
        ctrl.sliceOp      <= nextOp;
        ctrl.invertB      <= nextInvertB;
        ctrl.invertResult <= nextInvertResult;
      end
    end
  end

endmodule

//--- src/aluBitSlice.sv
`timescale 1ns/100ps

module aluBitSlice #(
  parameter int WIDTH = 32,
  parameter int BIT   = 0
) (
  aluSliceIf.slice sliceIo,
  input  logic     carryIn,
  output logic     carryOut
);
  import aluPkg::*;

  logic a;
  logic bMod;    // b after the subtract-mode xor
  logic aXorB;
  logic sum;
  logic laneMux;
  logic laneOut;

  assign a     = sliceIo.opA[BIT];
  assign bMod  = sliceIo.opB[BIT] ^ sliceIo.invertB;
  assign aXorB = a ^ bMod;

  // one full adder per bit
  assign sum      = aXorB ^ carryIn;
  assign carryOut = (a & bMod) | (aXorB & carryIn);

  // bMod equals plain b for the logic ops since invertB is low
  always_comb
  begin
    unique case (sliceIo.sliceOp)
      opSum:   laneMux = sum;
      opXor:   laneMux = aXorB;
      opAnd:   laneMux = a & bMod;
      opOr:    laneMux = a | bMod;
      default: laneMux = sum;
    endcase
  end

  assign laneOut = laneMux ^ sliceIo.invertResult; // nand / nor

  assign sliceIo.resultBits[BIT] = laneOut;
  assign sliceIo.carries[BIT]    = carryOut;

endmodule

//--- src/aluResultCollector.sv
`timescale 1ns/100ps

module aluResultCollector #(
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             reset,
  aluSliceIf.collector     sliceRes,
  output logic [WIDTH-1:0] result,
  output logic             carryout,
  output logic             zero,
  output logic             overflow,
  output logic             resultValid
);
  import aluPkg::*;

  logic             msbCarryOut;
  logic             msbCarryIn;
  logic             arithOverflow;
  logic             lessThan;
  logic             isArith;
  logic [WIDTH-1:0] nextResult;
  logic             nextZero;

  assign msbCarryOut   = sliceRes.carries[WIDTH-1];
  assign msbCarryIn    = sliceRes.carries[WIDTH-2];
  assign arithOverflow = msbCarryIn ^ msbCarryOut;

  // sign of a - b corrected by overflow
  assign lessThan = sliceRes.resultBits[WIDTH-1] ^ arithOverflow;

  always_comb
  begin
    isArith = 1'b0;
    case (sliceRes.cmd)
      cmdAdd, cmdSub, cmdSlt: isArith = 1'b1;
      default:                isArith = 1'b0;
    endcase
  end

  always_comb
  begin
    if (sliceRes.cmd == cmdSlt)
    begin
      nextResult = '0;
      nextResult[0] = lessThan;
    end
    else
    begin
      nextResult = sliceRes.resultBits;
    end
  end

  assign nextZero = (nextResult == '0);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      resultValid <= 1'b0;
      result      <= '0;
      carryout    <= 1'b0;
      zero        <= 1'b0;
      overflow    <= 1'b0;
    end
    else
    begin
      resultValid <= sliceRes.stageValid;
      if (sliceRes.stageValid) // hold outputs otherwise
      begin
        result   <= nextResult;
        zero     <= nextZero;
        carryout <= isArith & msbCarryOut;   // logic ops report 0
        overflow <= isArith & arithOverflow;
      end
    end
  end

endmodule

//--- src/aluCore.sv
`timescale 1ns/100ps

module aluCore #(
  parameter int WIDTH = aluPkg::ALU_WIDTH
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             opValid,
  input  logic [WIDTH-1:0] operandA,
  input  logic [WIDTH-1:0] operandB,
  input  aluPkg::aluCmdT   command,
  output logic [WIDTH-1:0] result,
  output logic             carryout,
  output logic             zero,
  output logic             overflow,
  output logic             resultValid
);

  aluSliceIf #(.WIDTH(WIDTH)) sliceBus ();

  wire [WIDTH-1:0] carryChain; // ripple carry out of each slice
  wire [WIDTH-1:0] carryIn;

  // bit 0 takes the subtract mode as its carry in
  assign carryIn = {carryChain[WIDTH-2:0], sliceBus.invertB};

  aluOpDecoder #(.WIDTH(WIDTH)) decoder0 (
    .clk      (clk),
    .reset    (reset),
    .opValid  (opValid),
    .operandA (operandA),
    .operandB (operandB),
    .command  (command),
    .ctrl     (sliceBus.decoder)
  );

  for (genvar i = 0; i < WIDTH; i++)
  begin : gSlice
    aluBitSlice #(.WIDTH(WIDTH), .BIT(i)) slice0 (
      .sliceIo  (sliceBus.slice),
      .carryIn  (carryIn[i]),
      .carryOut (carryChain[i])
    );
  end

  aluResultCollector #(.WIDTH(WIDTH)) collector0 (
    .clk         (clk),
    .reset       (reset),
    .sliceRes    (sliceBus.collector),
    .result      (result),
    .carryout    (carryout),
    .zero        (zero),
    .overflow    (overflow),
    .resultValid (resultValid)
  );

endmodule

//--- sim/aluCore_sva.sv
`timescale 1ns/100ps

module aluCoreSva #(
  parameter int WIDTH = 32
) (
  input logic             clk,
  input logic             reset,
  input logic             opValid,
  input aluPkg::aluCmdT   command,
  input logic [WIDTH-1:0] result,
  input logic             carryout,
  input logic             zero,
  input logic             overflow,
  input logic             resultValid
);
  import aluPkg::*;

  // two register stages between strobe in and strobe out
  aValidLatency: assert property (@(posedge clk) disable iff (reset)
    opValid |-> ##2 resultValid)
    else $error("resultValid missing two cycles after opValid");

  aNoStrayValid: assert property (@(posedge clk) disable iff (reset)
    resultValid |-> $past(opValid, 2))
    else $error("resultValid without opValid two cycles earlier");

  // command seen two cycles back belongs to this result
  aLogicFlags: assert property (@(posedge clk) disable iff (reset)
    resultValid && !($past(command, 2) inside {cmdAdd, cmdSub, cmdSlt})
      |-> !carryout && !overflow)
    else $error("carryout or overflow set for a logic command");

  aZeroFlag: assert property (@(posedge clk) disable iff (reset)
    resultValid |-> zero == (result == '0))
    else $error("zero flag disagrees with result");

endmodule

//--- sim/aluCoreTb.sv
`timescale 1ns/100ps

module aluCoreTb;
  import aluPkg::*;

  localparam int WIDTH          = ALU_WIDTH;
  localparam int PIPE_DEPTH     = 2;
  localparam int RESET_CYCLES   = 5;
  localparam int TOTAL_OPS      = 13 + 15 + 9 + 40; // addSub, logic, slt, stream
  localparam int TIMEOUT_CYCLES = (TOTAL_OPS + PIPE_DEPTH) * 2 + RESET_CYCLES;
  localparam logic [WIDTH-1:0] ALL_ONES = '1;
  localparam logic [WIDTH-1:0] MIN_NEG  = {1'b1, {(WIDTH-1){1'b0}}};
  localparam logic [WIDTH-1:0] MAX_POS  = {1'b0, {(WIDTH-1){1'b1}}};
  localparam logic [WIDTH-1:0] PAT_A    = WIDTH'(64'h5555_5555_5555_5555);
  localparam logic [WIDTH-1:0] PAT_B    = WIDTH'(64'h3333_3333_3333_3333);

  typedef struct packed
  {
    logic [WIDTH-1:0] res;
    logic             cy;
    logic             z;
    logic             ov;
    logic [31:0]      due; // cycle count at which the result shows up
  } expectT;

  logic             clk = 1'b0;
  logic             reset;
  logic             opValid;
  logic [WIDTH-1:0] operandA;
  logic [WIDTH-1:0] operandB;
  aluCmdT           command;
  logic [WIDTH-1:0] result;
  logic             carryout;
  logic             zero;
  logic             overflow;
  logic             resultValid;

  integer seed = 32'h87c2b5be;
  int     cycleCount = 0;
  int     errorCount = 0;
  int     checkCount = 0;
  expectT expQ[$];

  always #2 clk = ~clk;

  aluCore #(.WIDTH(WIDTH)) dut0 (
    .clk         (clk),
    .reset       (reset),
    .opValid     (opValid),
    .operandA    (operandA),
    .operandB    (operandB),
    .command     (command),
    .result      (result),
    .carryout    (carryout),
    .zero        (zero),
    .overflow    (overflow),
    .resultValid (resultValid)
  );

  bind aluCore aluCoreSva #(.WIDTH(WIDTH)) sva0 (
    .clk         (clk),
    .reset       (reset),
    .opValid     (opValid),
    .command     (command),
    .result      (result),
    .carryout    (carryout),
    .zero        (zero),
    .overflow    (overflow),
    .resultValid (resultValid)
  );

  task automatic checkWord(input string name, input logic [WIDTH-1:0] actual,
                           input logic [WIDTH-1:0] expected);
    checkCount++;
    if (actual !== expected)
    begin
      $display("Mismatch %s: got %h, expected %h", name, actual, expected);
      errorCount++;
    end
  endtask

  task automatic checkFlag(input string name, input logic actual, input logic expected);
    checkCount++;
    if (actual !== expected)
    begin
      $display("Mismatch %s: got %h, expected %h", name, actual, expected);
      errorCount++;
    end
  endtask

  function automatic logic [WIDTH-1:0] randWord();
    return WIDTH'($random(seed));
  endfunction

  // expected result and flags straight from the command rules
  function automatic expectT modelAlu(input aluCmdT cmd, input logic [WIDTH-1:0] a,
                                      input logic [WIDTH-1:0] b);
    expectT         e;
    logic [WIDTH:0] wide;
    e = '0;
    case (cmd)
      cmdAdd:
      begin
        wide  = {1'b0, a} + {1'b0, b};
        e.res = wide[WIDTH-1:0];
        e.cy  = wide[WIDTH];
        e.ov  = (a[WIDTH-1] == b[WIDTH-1]) && (e.res[WIDTH-1] != a[WIDTH-1]);
      end
      cmdSub,
      cmdSlt:
      begin
        e.res = a - b;
        e.cy  = (a >= b); // carry set when no borrow
        e.ov  = (a[WIDTH-1] != b[WIDTH-1]) && (e.res[WIDTH-1] != a[WIDTH-1]);
        if (cmd == cmdSlt)
        begin
          e.res    = '0;
          e.res[0] = $signed(a) < $signed(b);
        end
      end
      cmdXor:  e.res = a ^ b;
      cmdAnd:  e.res = a & b;
      cmdNand: e.res = ~(a & b);
      cmdNor:  e.res = ~(a | b);
      default: e.res = a | b;
    endcase
    e.z = (e.res == '0);
    return e;
  endfunction

  // called on a falling edge and returns on the next one
  task automatic issueOp(input aluCmdT cmd, input logic [WIDTH-1:0] a,
                         input logic [WIDTH-1:0] b);
    expectT e;
    e       = modelAlu(cmd, a, b);
    e.due   = 32'(cycleCount + PIPE_DEPTH);
    operandA = a;
    operandB = b;
    command  = cmd;
    opValid  = 1'b1;
    expQ.push_back(e);
    @(negedge clk);
  endtask

  task automatic finishTest(input string name, input int errStart, input int ops);
    int waited;
    opValid = 1'b0;
    waited  = 0;
    do
    begin
      @(posedge clk); // queue is only looked at between falling edges
      waited++;
    end
    while (expQ.size() != 0 && waited < PIPE_DEPTH + 2);
    if (expQ.size() != 0)
    begin
      $display("%s: %0d results never arrived", name, expQ.size());
      errorCount += expQ.size();
      expQ.delete();
    end
    @(negedge clk);
    $display("test %s: %0d ops, %0d errors", name, ops, errorCount - errStart);
  endtask

  // pops one expected entry per resultValid
  always @(negedge clk)
  begin : monitorBlk
    expectT e;
    if (!reset && resultValid)
    begin
      if (expQ.size() == 0)
      begin
        $display("Unexpected resultValid at cycle %0d with nothing in flight", cycleCount);
        errorCount++;
      end
      else
      begin
        e = expQ.pop_front();
        if (e.due != 32'(cycleCount))
        begin
          $display("Result arrived at cycle %0d but was due at cycle %0d", cycleCount, e.due);
          errorCount++;
        end
        checkWord("result", result, e.res);
        checkFlag("carryout", carryout, e.cy);
        checkFlag("zero", zero, e.z);
        checkFlag("overflow", overflow, e.ov);
      end
    end
  end

  always @(posedge clk)
  begin
    cycleCount++;
    if (cycleCount > TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles, the test sequence did not finish", cycleCount);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  task automatic testResetState();
    int errStart;
    errStart = errorCount;
    repeat (3)
    begin
      checkFlag("resultValid", resultValid, 1'b0);
      checkWord("result", result, '0);
      checkFlag("carryout", carryout, 1'b0);
      checkFlag("zero", zero, 1'b0);
      checkFlag("overflow", overflow, 1'b0);
      @(negedge clk);
    end
    $display("test reset: 0 ops, %0d errors", errorCount - errStart);
  endtask

  task automatic testAddSub();
    int errStart;
    errStart = errorCount;
    issueOp(cmdAdd, WIDTH'(5), WIDTH'(7));
    issueOp(cmdAdd, ALL_ONES, WIDTH'(1)); // carry out and zero
    issueOp(cmdAdd, MAX_POS, WIDTH'(1));  // positive overflow
    issueOp(cmdAdd, MIN_NEG, MIN_NEG);    // negative overflow
    issueOp(cmdSub, WIDTH'(10), WIDTH'(3));
    issueOp(cmdSub, PAT_A, PAT_A);
    issueOp(cmdSub, WIDTH'(3), WIDTH'(10));
    issueOp(cmdSub, MIN_NEG, WIDTH'(1));
    issueOp(cmdSub, MAX_POS, ALL_ONES);   // max positive minus -1
    repeat (2)
    begin
      issueOp(cmdAdd, randWord(), randWord());
      issueOp(cmdSub, randWord(), randWord());
    end
    finishTest("addSub", errStart, 13);
  endtask

  task automatic testLogic();
    aluCmdT logicCmds [5];
    int     errStart;
    logicCmds = '{cmdXor, cmdAnd, cmdNand, cmdNor, cmdOr};
    errStart  = errorCount;
    foreach (logicCmds[i])
    begin
      issueOp(logicCmds[i], PAT_A, PAT_B);
      issueOp(logicCmds[i], ALL_ONES, '0);
      issueOp(logicCmds[i], randWord(), randWord());
    end
    finishTest("logic", errStart, 15);
  endtask

  task automatic testSlt();
    int errStart;
    errStart = errorCount;
    issueOp(cmdSlt, WIDTH'(3), WIDTH'(7));
    issueOp(cmdSlt, WIDTH'(7), WIDTH'(3));
    issueOp(cmdSlt, WIDTH'(-5), WIDTH'(-2));
    issueOp(cmdSlt, WIDTH'(-2), WIDTH'(-5));
    issueOp(cmdSlt, ALL_ONES, WIDTH'(1)); // -1 against 1
    issueOp(cmdSlt, WIDTH'(1), ALL_ONES);
    issueOp(cmdSlt, MIN_NEG, WIDTH'(1));  // subtraction overflows here
    issueOp(cmdSlt, MAX_POS, MIN_NEG);
    issueOp(cmdSlt, WIDTH'(4), WIDTH'(4));
    finishTest("slt", errStart, 9);
  endtask

  task automatic testStream();
    aluCmdT           cmd;
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    int               errStart;
    errStart = errorCount;
    repeat (40) // opValid stays high the whole time
    begin
      cmd = aluCmdT'(3'($random(seed)));
      a   = randWord();
      b   = randWord();
      issueOp(cmd, a, b);
    end
    finishTest("stream", errStart, 40);
  endtask

  initial
  begin
    reset    = 1'b1;
    opValid  = 1'b0;
    operandA = '0;
    operandB = '0;
    command  = cmdAdd;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    testResetState();
    testAddSub();
    testLogic();
    testSlt();
    testStream();
    $display("summary: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- aluCore.f
src/aluPkg.sv
src/aluSliceIf.sv
src/aluOpDecoder.sv
src/aluBitSlice.sv
src/aluResultCollector.sv
src/aluCore.sv
sim/aluCore_sva.sv
sim/aluCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module aluCoreTb -f aluCore.f -Mdir obj_dir -o aluCoreSim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

simOutput=$(./obj_dir/aluCoreSim)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if echo "$simOutput" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
fi
echo "pass message not found"
exit 1
